// ==== dbg_mem_port_top.f ====
+incdir+tests
hw/dbg_ram_pkg.sv
hw/dbg_stream_fifo.sv
hw/wb_beat_counter.sv
hw/wb_burst_fsm.sv
hw/wb_ram_b3.sv
hw/dbg_mem_port_top.sv
tests/tb_dbg_mem_port_top.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_dbg_mem_port_top
FILELIST  := dbg_mem_port_top.f
BUILD     := obj_dir
PASS_MSG  := ALL CHECKS PASSED

SRCS := $(shell grep -v '^+' $(FILELIST)) tests/tb_dbg_vectors.svh
SIM  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// ==== tests/tb_dbg_vectors.svh ====
/*
 * Stimulus and expected-value table for the debug memory port testbench.
 * One row per command: name, command fields, write word base,
 * expected response count and per-beat error flags.
 */

localparam int NUM_ROWS = 14;

string                 row_name  [NUM_ROWS];
dbg_ram_pkg::dbg_cmd_t row_cmd   [NUM_ROWS];
// Write beat k carries wbase + k * 0x01010101
logic [31:0]           row_wbase [NUM_ROWS];
int                    row_nrsp  [NUM_ROWS];
// Bit k set when beat k must report err
logic [15:0]           row_err   [NUM_ROWS];
int                    row_fill;

task automatic add_row(input string name, input logic [31:0] adr, input logic we,
                       input logic [3:0] sel, input dbg_ram_pkg::burst_len_e len,
                       input logic wrap, input logic [31:0] wbase, input int nrsp,
                       input logic [15:0] err);
  row_name[row_fill]      = name;
  row_cmd[row_fill].adr   = adr;
  row_cmd[row_fill].we    = we;
  row_cmd[row_fill].sel   = sel;
  row_cmd[row_fill].len   = len;
  row_cmd[row_fill].wrap  = wrap;
  row_wbase[row_fill]     = wbase;
  row_nrsp[row_fill]      = nrsp;
  row_err[row_fill]       = err;
  row_fill++;
endtask

task automatic load_vectors();
  row_fill = 0;
  // Single write and read back
  add_row("wr_single", 32'h0000_0010, 1'b1, 4'hF, dbg_ram_pkg::LEN_1, 1'b0,
          32'hA5A5_1234, 1, 16'h0000);
  add_row("rd_single", 32'h0000_0010, 1'b0, 4'hF, dbg_ram_pkg::LEN_1, 1'b0, '0, 1, 16'h0000);
  // Fill words 0x40..0x4F, then read from the middle and in wrap order
  add_row("wr_lin16", 32'h0000_0100, 1'b1, 4'hF, dbg_ram_pkg::LEN_16, 1'b0,
          32'h1000_0001, 16, 16'h0000);
  add_row("rd_lin8_mid", 32'h0000_0110, 1'b0, 4'hF, dbg_ram_pkg::LEN_8, 1'b0, '0, 8, 16'h0000);
  add_row("rd_wrap4", 32'h0000_0108, 1'b0, 4'hF, dbg_ram_pkg::LEN_4, 1'b1, '0, 4, 16'h0000);
  add_row("rd_wrap8", 32'h0000_0114, 1'b0, 4'hF, dbg_ram_pkg::LEN_8, 1'b1, '0, 8, 16'h0000);
  // Bytes 0 and 2 only
  add_row("wr_partial", 32'h0000_0010, 1'b1, 4'b0101, dbg_ram_pkg::LEN_1, 1'b0,
          32'hFFEE_DDCC, 1, 16'h0000);
  add_row("rd_partial", 32'h0000_0010, 1'b0, 4'hF, dbg_ram_pkg::LEN_1, 1'b0, '0, 1, 16'h0000);
  // Outside the window, every beat errs
  add_row("rd_bad", 32'h0010_0000, 1'b0, 4'hF, dbg_ram_pkg::LEN_4, 1'b0, '0, 4, 16'h000F);
  add_row("wr_bad", 32'h0200_0040, 1'b1, 4'hF, dbg_ram_pkg::LEN_8, 1'b0,
          32'hDEAD_0000, 8, 16'h00FF);
  add_row("rd_after_bad", 32'h0000_0100, 1'b0, 4'hF, dbg_ram_pkg::LEN_4, 1'b0, '0, 4, 16'h0000);
  add_row("wr_wrap16", 32'h0000_0118, 1'b1, 4'hF, dbg_ram_pkg::LEN_16, 1'b1,
          32'h5A00_0000, 16, 16'h0000);
  add_row("rd_lin16", 32'h0000_0100, 1'b0, 4'hF, dbg_ram_pkg::LEN_16, 1'b0, '0, 16, 16'h0000);
  // Top nibble is not decoded
  add_row("rd_top_nibble", 32'hF000_0010, 1'b0, 4'hF, dbg_ram_pkg::LEN_1, 1'b0, '0, 1,
          16'h0000);
endtask

// ==== tests/tb_dbg_mem_port_top.sv ====
/*
 * Testbench for the debug memory port top level.
 * Clock and reset, table driven command and write data streams,
 * reference word memory, in-order response checks and timeout.
 */

`timescale 1ns/1ps

module tb_dbg_mem_port_top;

  logic                       wb_clk_i;
  logic                       wb_rst_i;
  logic                       cmd_valid_i;
  logic                       cmd_ready_o;
  dbg_ram_pkg::dbg_cmd_t      cmd_i;
  logic                       wdata_valid_i;
  logic                       wdata_ready_o;
  logic [dbg_ram_pkg::DW-1:0] wdata_i;
  logic                       rsp_valid_o;
  logic                       rsp_ready_i;
  dbg_ram_pkg::dbg_rsp_t      rsp_o;

  `include "tb_dbg_vectors.svh"

  // Reference RAM and expected beats in response order
  logic [31:0] ref_mem [1024];
  logic [31:0] exp_dat [$];
  logic        exp_err [$];
  logic        exp_chk [$];
  int          exp_row [$];

  int seed = 58282;
  int errors = 0;
  int checks = 0;
  int cycles = 0;

  dbg_mem_port_top dbg_mem_port_top_inst (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_ready_o   (cmd_ready_o),
    .cmd_i         (cmd_i),
    .wdata_valid_i (wdata_valid_i),
    .wdata_ready_o (wdata_ready_o),
    .wdata_i       (wdata_i),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_ready_i   (rsp_ready_i),
    .rsp_o         (rsp_o)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #5 wb_clk_i = ~wb_clk_i;
  end

  // Budget of 200 cycles per row
  always @(posedge wb_clk_i) begin
    cycles++;
    if (cycles >= 200 * NUM_ROWS) begin
      $display("Timeout after %0d cycles, responses still missing", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] write_word(input int r, input int k);
    return row_wbase[r] + 32'(k) * 32'h0101_0101;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Expected responses
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_expected();
    dbg_ram_pkg::dbg_cmd_t c;
    logic [9:0]            start;
    logic [9:0]            mask;
    logic [9:0]            wa;
    logic [31:0]           w;
    for (int r = 0; r < NUM_ROWS; r++) begin
      c     = row_cmd[r];
      start = c.adr[11:2];
      // Wrap block size follows the beat count
      mask  = (c.wrap && c.len != dbg_ram_pkg::LEN_1) ? 10'(row_nrsp[r] - 1) : '1;
      for (int k = 0; k < row_nrsp[r]; k++) begin
        wa = (start & ~mask) | (10'(start + 10'(k)) & mask);
        exp_err.push_back(row_err[r][k]);
        exp_row.push_back(r);
        if (row_err[r][k]) begin
          // No bus access, data undefined
          exp_dat.push_back('0);
          exp_chk.push_back(1'b0);
        end else if (c.we) begin
          w = write_word(r, k);
          for (int b = 0; b < 4; b++) begin
            if (c.sel[b]) begin
              ref_mem[wa][b*8 +: 8] = w[b*8 +: 8];
            end
          end
          exp_dat.push_back('0);
          exp_chk.push_back(1'b1);
        end else begin
          exp_dat.push_back(ref_mem[wa]);
          exp_chk.push_back(1'b1);
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stream drivers and response checker
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_commands();
    for (int r = 0; r < NUM_ROWS; r++) begin
      cmd_valid_i <= 1'b1;
      cmd_i       <= row_cmd[r];
      @(posedge wb_clk_i);
      while (!cmd_ready_o) @(posedge wb_clk_i);
    end
    cmd_valid_i <= 1'b0;
  endtask

  // Error bursts still drain all their write words
  task automatic send_wdata();
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (row_cmd[r].we) begin
        for (int k = 0; k < row_nrsp[r]; k++) begin
          wdata_valid_i <= 1'b1;
          wdata_i       <= write_word(r, k);
          @(posedge wb_clk_i);
          while (!wdata_ready_o) @(posedge wb_clk_i);
        end
      end
    end
    wdata_valid_i <= 1'b0;
  endtask

  task automatic collect_responses();
    dbg_ram_pkg::dbg_rsp_t got;
    int                    idx;
    int                    beat;
    int                    row_errs;
    idx      = 0;
    beat     = 0;
    row_errs = 0;
    while (idx < exp_err.size()) begin
      @(posedge wb_clk_i);
      if (rsp_valid_o && rsp_ready_i) begin
        got = rsp_o;
        checks++;
        assert (got.err == exp_err[idx]) else begin
          $display("CHECK FAILED %s beat %0d: rsp_o.err = %h, expected %h",
                   row_name[exp_row[idx]], beat, got.err, exp_err[idx]);
          errors++;
          row_errs++;
        end
        if (exp_chk[idx]) begin
          checks++;
          assert (got.dat == exp_dat[idx]) else begin
            $display("CHECK FAILED %s beat %0d: rsp_o.dat = %h, expected %h",
                     row_name[exp_row[idx]], beat, got.dat, exp_dat[idx]);
            errors++;
            row_errs++;
          end
        end
        beat++;
        // Row done on its last beat
        if (idx + 1 == exp_err.size() || exp_row[idx + 1] != exp_row[idx]) begin
          $display("test %-14s %2d beats, %0d mismatches",
                   row_name[exp_row[idx]], beat, row_errs);
          beat     = 0;
          row_errs = 0;
        end
        idx++;
      end
      // Random back-pressure on the response stream
      rsp_ready_i <= ($random(seed) % 2) != 0;
    end
    rsp_ready_i <= 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    wb_rst_i      = 1'b1;
    cmd_valid_i   = 1'b0;
    cmd_i         = '0;
    wdata_valid_i = 1'b0;
    wdata_i       = '0;
    rsp_ready_i   = 1'b0;

    load_vectors();
    build_expected();

    repeat (5) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;

    fork
      send_commands();
      send_wdata();
      collect_responses();
    join

    // Nothing may follow the last expected beat
    repeat (10) begin
      @(posedge wb_clk_i);
      assert (!rsp_valid_o) else begin
        $display("Extra response seen after the last expected beat");
        errors++;
      end
    end

    $display("%0d tests, %0d checks, %0d errors", NUM_ROWS, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== hw/dbg_mem_port_top.sv ====
/*
 * Debug memory port top level.
 * Command and response FIFOs, burst engine, beat counter and RAM.
 */

`timescale 1ns/1ps

module dbg_mem_port_top (
  input  logic                       wb_clk_i,
  input  logic                       wb_rst_i,

  input  logic                       cmd_valid_i,
  output logic                       cmd_ready_o,
  input  dbg_ram_pkg::dbg_cmd_t      cmd_i,

  input  logic                       wdata_valid_i,
  output logic                       wdata_ready_o,
  input  logic [dbg_ram_pkg::DW-1:0] wdata_i,

  output logic                       rsp_valid_o,
  input  logic                       rsp_ready_i,
  output dbg_ram_pkg::dbg_rsp_t      rsp_o
);

  // Command FIFO to engine
  logic                            cmd_fifo_valid;
  logic                            cmd_fifo_ready;
  dbg_ram_pkg::dbg_cmd_t           cmd_fifo_data;

  // Engine to response FIFO
  logic                            rsp_fsm_valid;
  logic                            rsp_fsm_ready;
  dbg_ram_pkg::dbg_rsp_t           rsp_fsm_data;

  dbg_ram_pkg::wb_req_t            wb_req;
  dbg_ram_pkg::wb_rsp_t            wb_rsp;

  logic                            cnt_load;
  logic                            cnt_advance;
  logic [dbg_ram_pkg::WORD_AW-1:0] cnt_word_adr;
  logic                            cnt_last;

  dbg_stream_fifo #(
    .payload_t (dbg_ram_pkg::dbg_cmd_t)
  ) cmd_fifo (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .in_valid_i  (cmd_valid_i),
    .in_ready_o  (cmd_ready_o),
    .in_data_i   (cmd_i),
    .out_valid_o (cmd_fifo_valid),
    .out_ready_i (cmd_fifo_ready),
    .out_data_o  (cmd_fifo_data)
  );

  // Loaded straight from the FIFO head as the engine pops it
  wb_beat_counter beat_counter (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .load_i      (cnt_load),
    .start_adr_i (cmd_fifo_data.adr[dbg_ram_pkg::MEM_ADR_WIDTH-1:2]),
    .len_i       (cmd_fifo_data.len),
    .wrap_i      (cmd_fifo_data.wrap),
    .advance_i   (cnt_advance),
    .word_adr_o  (cnt_word_adr),
    .last_o      (cnt_last)
  );

  wb_burst_fsm burst_fsm (
    .wb_clk_i       (wb_clk_i),
    .wb_rst_i       (wb_rst_i),
    .cmd_valid_i    (cmd_fifo_valid),
    .cmd_ready_o    (cmd_fifo_ready),
    .cmd_i          (cmd_fifo_data),
    .wdata_valid_i  (wdata_valid_i),
    .wdata_ready_o  (wdata_ready_o),
    .wdata_i        (wdata_i),
    .rsp_valid_o    (rsp_fsm_valid),
    .rsp_ready_i    (rsp_fsm_ready),
    .rsp_o          (rsp_fsm_data),
    .wb_req_o       (wb_req),
    .wb_rsp_i       (wb_rsp),
    .cnt_load_o     (cnt_load),
    .cnt_advance_o  (cnt_advance),
    .cnt_word_adr_i (cnt_word_adr),
    .cnt_last_i     (cnt_last)
  );

  wb_ram_b3 ram (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp)
  );

  dbg_stream_fifo #(
    .payload_t (dbg_ram_pkg::dbg_rsp_t)
  ) rsp_fifo (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .in_valid_i  (rsp_fsm_valid),
    .in_ready_o  (rsp_fsm_ready),
    .in_data_i   (rsp_fsm_data),
    .out_valid_o (rsp_valid_o),
    .out_ready_i (rsp_ready_i),
    .out_data_o  (rsp_o)
  );

endmodule

// ==== hw/wb_ram_b3.sv ====
/*
 * Word RAM behind a Wishbone B3 slave with registered feedback.
 * Burst address tracking, per cycle type ack timing, byte select
 * read-modify-write and error on addresses outside the window.
 */

`timescale 1ns/1ps

module wb_ram_b3 (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,

  input  dbg_ram_pkg::wb_req_t wb_req_i,
  output dbg_ram_pkg::wb_rsp_t wb_rsp_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Storage and state
  ////////////////////////////////////////////////////////////////////////////

  logic [dbg_ram_pkg::DW-1:0]      mem [0:(1 << dbg_ram_pkg::WORD_AW)-1];

  // Registered word address, read port runs from it
  logic [dbg_ram_pkg::WORD_AW-1:0] adr_q;
  // Expected address of the next burst beat
  logic [dbg_ram_pkg::WORD_AW-1:0] burst_adr;
  logic [dbg_ram_pkg::WORD_AW-1:0] req_word;

  // Inside a B3 incrementing burst
  logic                            b3_trans_q;
  logic                            b3_start;
  logic                            b3_stop;

  // Cycle and burst type of the previous cycle
  dbg_ram_pkg::cti_e               cti_q;
  dbg_ram_pkg::bte_e               bte_q;

  logic                            ack_q;
  logic                            adr_err;
  logic                            burst_adr_err;
  logic [dbg_ram_pkg::DW-1:0]      rd_data;
  logic [dbg_ram_pkg::DW-1:0]      wr_data;
  logic                            ram_we;

  ////////////////////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    req_word = wb_req_i.adr[dbg_ram_pkg::MEM_ADR_WIDTH-1:2];

    // Top nibble ignored, RAM may be mapped above 0x0
    adr_err = wb_req_i.cyc && wb_req_i.stb &&
              (|wb_req_i.adr[dbg_ram_pkg::AW-5:dbg_ram_pkg::MEM_ADR_WIDTH]);
    // Master left the burst sequence
    burst_adr_err = b3_trans_q && (adr_q != req_word);

    rd_data      = mem[adr_q];
    wb_rsp_o.dat = rd_data;
    // err takes the place of ack, same timing
    wb_rsp_o.ack = ack_q && wb_req_i.stb && !(burst_adr_err || adr_err);
    wb_rsp_o.err = ack_q && wb_req_i.stb && (burst_adr_err || adr_err);

    b3_start = wb_req_i.cyc && wb_req_i.stb && !b3_trans_q &&
               (wb_req_i.cti == dbg_ram_pkg::CTI_INCR);
    b3_stop  = ((wb_req_i.cti == dbg_ram_pkg::CTI_EOB) && wb_req_i.stb &&
                b3_trans_q && wb_rsp_o.ack) || wb_rsp_o.err;

    ram_we = wb_req_i.we && wb_rsp_o.ack;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Burst tracking
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      b3_trans_q <= 1'b0;
    end else if (b3_start) begin
      b3_trans_q <= 1'b1;
    end else if (b3_stop) begin
      b3_trans_q <= 1'b0;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    cti_q <= wb_req_i.cti;
    bte_q <= wb_req_i.bte;
  end

  // Step on each acked incrementing beat, wrap inside the block
  always_comb begin
    burst_adr = adr_q;
    if ((cti_q == dbg_ram_pkg::CTI_INCR) && wb_rsp_o.ack && b3_trans_q) begin
      case (bte_q)
        dbg_ram_pkg::BTE_LINEAR: burst_adr      = adr_q + 1'b1;
        dbg_ram_pkg::BTE_WRAP4:  burst_adr[1:0] = adr_q[1:0] + 1'b1;
        dbg_ram_pkg::BTE_WRAP8:  burst_adr[2:0] = adr_q[2:0] + 1'b1;
        dbg_ram_pkg::BTE_WRAP16: burst_adr[3:0] = adr_q[3:0] + 1'b1;
        default:                 burst_adr      = adr_q;
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      adr_q <= '0;
    end else if (b3_trans_q) begin
      adr_q <= burst_adr;
    end else if (wb_req_i.cyc && wb_req_i.stb) begin
      adr_q <= req_word;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write path
  ////////////////////////////////////////////////////////////////////////////

  // Unselected bytes keep the stored value
  always_comb begin
    for (int b = 0; b < dbg_ram_pkg::DW / 8; b++) begin
      wr_data[b*8 +: 8] = wb_req_i.sel[b] ? wb_req_i.dat[b*8 +: 8] : rd_data[b*8 +: 8];
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (ram_we) begin
      mem[adr_q] <= wr_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registered feedback ack
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
    end else if (wb_req_i.cyc) begin
      if (adr_err && wb_req_i.stb) begin
        ack_q <= 1'b1;
      end else if (wb_req_i.cti == dbg_ram_pkg::CTI_CLASSIC) begin
        // Classic, ack then one idle cycle
        ack_q <= wb_req_i.stb ^ ack_q;
      end else if (wb_req_i.cti == dbg_ram_pkg::CTI_INCR) begin
        ack_q <= wb_req_i.stb;
      end else if (wb_req_i.cti == dbg_ram_pkg::CTI_EOB) begin
        ack_q <= wb_req_i.stb && !ack_q;
      end
    end else begin
      ack_q <= 1'b0;
    end
  end

  // Master closes the cycle after an err
  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_rsp_o.err |=> !(wb_rsp_o.ack || wb_rsp_o.err));

endmodule

// ==== hw/wb_burst_fsm.sv ====
/*
 * Burst engine for the debug memory port.
 * Turns one host command into one Wishbone B3 cycle, feeds write data,
 * returns one response per beat and flushes aborted bursts.
 */

`timescale 1ns/1ps

module wb_burst_fsm (
  input  logic                            wb_clk_i,
  input  logic                            wb_rst_i,

  input  logic                            cmd_valid_i,
  output logic                            cmd_ready_o,
  input  dbg_ram_pkg::dbg_cmd_t           cmd_i,

  input  logic                            wdata_valid_i,
  output logic                            wdata_ready_o,
  input  logic [dbg_ram_pkg::DW-1:0]      wdata_i,

  output logic                            rsp_valid_o,
  input  logic                            rsp_ready_i,
  output dbg_ram_pkg::dbg_rsp_t           rsp_o,

  output dbg_ram_pkg::wb_req_t            wb_req_o,
  input  dbg_ram_pkg::wb_rsp_t            wb_rsp_i,

  output logic                            cnt_load_o,
  output logic                            cnt_advance_o,
  input  logic [dbg_ram_pkg::WORD_AW-1:0] cnt_word_adr_i,
  input  logic                            cnt_last_i
);

  typedef enum logic [1:0] {
    IDLE,
    BUS,
    FLUSH
  } state_e;

  state_e                       state_q;
  state_e                       state_d;
  dbg_ram_pkg::dbg_cmd_t        cmd_q;
  // Write word taken for the current beat, held until ack
  logic [dbg_ram_pkg::DW-1:0]   wdata_q;
  logic                         have_wd_q;
  logic                         beat_ok;
  logic                         beat_done;
  logic                         flush_done;
  logic                         wd_take;

  ////////////////////////////////////////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Reads always ready, writes need a word
    beat_ok = !cmd_q.we || have_wd_q || wdata_valid_i;

    wb_req_o.adr = {cmd_q.adr[dbg_ram_pkg::AW-1:dbg_ram_pkg::MEM_ADR_WIDTH],
                    cnt_word_adr_i, 2'b00};
    wb_req_o.dat = have_wd_q ? wdata_q : wdata_i;
    wb_req_o.sel = cmd_q.sel;
    wb_req_o.we  = cmd_q.we;
    wb_req_o.cyc = (state_q == BUS);
    // Stall with stb low on full response FIFO or missing write data
    wb_req_o.stb = wb_req_o.cyc && beat_ok && rsp_ready_i;

    if (cmd_q.len == dbg_ram_pkg::LEN_1) begin
      wb_req_o.cti = dbg_ram_pkg::CTI_CLASSIC;
    end else if (cnt_last_i) begin
      wb_req_o.cti = dbg_ram_pkg::CTI_EOB;
    end else begin
      wb_req_o.cti = dbg_ram_pkg::CTI_INCR;
    end

    // Length codes line up with the wrap codes
    if (cmd_q.wrap && (cmd_q.len != dbg_ram_pkg::LEN_1)) begin
      wb_req_o.bte = dbg_ram_pkg::bte_e'(cmd_q.len);
    end else begin
      wb_req_o.bte = dbg_ram_pkg::BTE_LINEAR;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Host side
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    cmd_ready_o = (state_q == IDLE);
    cnt_load_o  = cmd_valid_i && cmd_ready_o;

    beat_done = (state_q == BUS) && (wb_rsp_i.ack || wb_rsp_i.err);

    // Word taken as stb rises; in flush just drained
    wdata_ready_o = cmd_q.we && rsp_ready_i &&
                    (((state_q == BUS) && !have_wd_q) || (state_q == FLUSH));
    wd_take       = wdata_ready_o && wdata_valid_i && (state_q == BUS);

    // Flush beats only wait on write data
    rsp_valid_o = beat_done ||
                  ((state_q == FLUSH) && (!cmd_q.we || wdata_valid_i));
    rsp_o.dat   = ((state_q == BUS) && !cmd_q.we) ? wb_rsp_i.dat : '0;
    rsp_o.err   = (state_q == FLUSH) || wb_rsp_i.err;
    flush_done  = (state_q == FLUSH) && rsp_valid_o && rsp_ready_i;

    cnt_advance_o = beat_done || flush_done;
  end

  ////////////////////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (cmd_valid_i) begin
          state_d = BUS;
        end
      end
      BUS: begin
        if (beat_done && cnt_last_i) begin
          state_d = IDLE;
        end else if (beat_done && wb_rsp_i.err) begin
          state_d = FLUSH;
        end
      end
      FLUSH: begin
        if (flush_done && cnt_last_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q   <= IDLE;
      have_wd_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      // Take and ack in one cycle leaves nothing held
      have_wd_q <= (have_wd_q || wd_take) && !beat_done;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (cnt_load_o) begin
      cmd_q <= cmd_i;
    end
    if (wd_take) begin
      wdata_q <= wdata_i;
    end
  end

  // stb held until the slave answers
  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_req_o.stb && !(wb_rsp_i.ack || wb_rsp_i.err) |=> wb_req_o.stb);

endmodule

// ==== hw/wb_beat_counter.sv ====
/*
 * Beat and word address counter for one Wishbone burst.
 * Linear bursts count over the full word address, wrapping bursts
 * only inside the aligned 4, 8 or 16 word block.
 */

`timescale 1ns/1ps

module wb_beat_counter (
  input  logic                            wb_clk_i,
  input  logic                            wb_rst_i,

  input  logic                            load_i,
  input  logic [dbg_ram_pkg::WORD_AW-1:0] start_adr_i,
  input  dbg_ram_pkg::burst_len_e         len_i,
  input  logic                            wrap_i,

  input  logic                            advance_i,

  output logic [dbg_ram_pkg::WORD_AW-1:0] word_adr_o,
  output logic                            last_o
);

  // Beats still to complete, up to 16
  logic [4:0]                      beats_q;
  logic [4:0]                      load_beats;
  // Address bits allowed to count
  logic [dbg_ram_pkg::WORD_AW-1:0] mask_q;
  logic [dbg_ram_pkg::WORD_AW-1:0] load_mask;
  logic [dbg_ram_pkg::WORD_AW-1:0] adr_q;

  always_comb begin
    case (len_i)
      dbg_ram_pkg::LEN_4:  load_beats = 5'd4;
      dbg_ram_pkg::LEN_8:  load_beats = 5'd8;
      dbg_ram_pkg::LEN_16: load_beats = 5'd16;
      default:             load_beats = 5'd1;
    endcase

    // Linear, every bit counts
    load_mask = '1;
    if (wrap_i) begin
      load_mask = '0;
      case (len_i)
        dbg_ram_pkg::LEN_4:  load_mask[1:0] = '1;
        dbg_ram_pkg::LEN_8:  load_mask[2:0] = '1;
        dbg_ram_pkg::LEN_16: load_mask[3:0] = '1;
        default:             load_mask      = '1;
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      beats_q <= '0;
    end else if (load_i) begin
      beats_q <= load_beats;
    end else if (advance_i) begin
      beats_q <= beats_q - 1'b1;
    end
  end

  // High bits frozen by the mask on wrapping bursts
  always_ff @(posedge wb_clk_i) begin
    if (load_i) begin
      adr_q  <= start_adr_i;
      mask_q <= load_mask;
    end else if (advance_i) begin
      adr_q <= (adr_q & ~mask_q) | ((adr_q + 1'b1) & mask_q);
    end
  end

  assign word_adr_o = adr_q;
  assign last_o     = (beats_q == 5'd1);

  // Engine never acks past the end of its burst
  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    advance_i |-> (beats_q != 5'd0));

endmodule

// ==== hw/dbg_stream_fifo.sv ====
/*
 * Small synchronous valid/ready FIFO.
 * Payload type is a parameter, shared by the command and response paths.
 */

`timescale 1ns/1ps

module dbg_stream_fifo #(
  parameter type payload_t = logic [dbg_ram_pkg::DW-1:0]
) (
  input  logic     wb_clk_i,
  input  logic     wb_rst_i,

  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,

  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  // Storage, no reset needed on payload
  payload_t store_q [dbg_ram_pkg::FIFO_DEPTH];

  logic [$clog2(dbg_ram_pkg::FIFO_DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(dbg_ram_pkg::FIFO_DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(dbg_ram_pkg::FIFO_DEPTH+1)-1:0] count_q;
  logic                                         push;
  logic                                         pop;

  always_comb begin
    in_ready_o  = (count_q != dbg_ram_pkg::FIFO_DEPTH);
    out_valid_o = (count_q != '0);
    // Head entry shown directly
    out_data_o  = store_q[rd_ptr_q];
    push        = in_valid_i && in_ready_o;
    pop         = out_valid_o && out_ready_i;
  end

  always_ff @(posedge wb_clk_i) begin
    if (push) begin
      store_q[wr_ptr_q] <= in_data_i;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Push and pop together keep the level
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Offer refused on a full buffer waits with the same payload
  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_data_i));

endmodule

// ==== hw/dbg_ram_pkg.sv ====
/*
 * Shared definitions for the debug memory port.
 * Bus and RAM sizes, Wishbone B3 cycle and burst type encodings,
 * host stream payloads and the Wishbone request/response bundles.
 */

package dbg_ram_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // Wishbone data and address width
  localparam int DW = 32;
  localparam int AW = 32;

  // Byte address bits decoded by the RAM, 4 KiB
  localparam int MEM_ADR_WIDTH = 12;
  // Word address bits, 1024 words
  localparam int WORD_AW = MEM_ADR_WIDTH - 2;

  // Entries per host stream FIFO
  localparam int FIFO_DEPTH = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Wishbone B3 cycle type identifier
  typedef enum logic [2:0] {
    CTI_CLASSIC = 3'b000,
    CTI_INCR    = 3'b010,
    CTI_EOB     = 3'b111
  } cti_e;

  // Burst type extension
  typedef enum logic [1:0] {
    BTE_LINEAR = 2'b00,
    BTE_WRAP4  = 2'b01,
    BTE_WRAP8  = 2'b10,
    BTE_WRAP16 = 2'b11
  } bte_e;

  // Command length code, same order as the wrap codes above
  typedef enum logic [1:0] {
    LEN_1  = 2'b00,
    LEN_4  = 2'b01,
    LEN_8  = 2'b10,
    LEN_16 = 2'b11
  } burst_len_e;

  ////////////////////////////////////////////////////////////////////////////
  // Payloads
  ////////////////////////////////////////////////////////////////////////////

  // One host command, a whole burst
  typedef struct packed {
    logic [AW-1:0] adr;
    logic          we;
    logic [3:0]    sel;
    burst_len_e    len;
    logic          wrap;
  } dbg_cmd_t;

  // One response per beat
  typedef struct packed {
    logic [DW-1:0] dat;
    logic          err;
  } dbg_rsp_t;

  // Master side of the bus
  typedef struct packed {
    logic [AW-1:0] adr;
    logic [DW-1:0] dat;
    logic [3:0]    sel;
    logic          we;
    cti_e          cti;
    bte_e          bte;
    logic          cyc;
    logic          stb;
  } wb_req_t;

  // Slave side of the bus
  typedef struct packed {
    logic [DW-1:0] dat;
    logic          ack;
    logic          err;
  } wb_rsp_t;

endpackage
